/* logic/ser_pkg.sv */
`default_nettype none

package ser_pkg;

   // ##########################################################
   // Widths
   // ##########################################################

   // Parallel word width
   localparam int PW = 64;

   // Serial lane width of one beat on the wire
   localparam int SW = 4;

   // Beats needed to move one word
   localparam int BEATS = PW / SW;

   // Beat counter width
   localparam int CW = $clog2(BEATS);

   // ##########################################################
   // Types
   // ##########################################################

   typedef logic [PW-1:0] word_t;
   typedef logic [SW-1:0] lane_t;
   typedef logic [CW-1:0] cnt_t;

   // Transmit sequencer states
   typedef enum logic {
      TX_IDLE,
      TX_SEND
   } tx_state_t;

   // Receive framer states
   typedef enum logic {
      RX_IDLE,
      RX_COLLECT
   } rx_state_t;

endpackage

`default_nettype wire

/* logic/ser_par2ser.sv */
`default_nettype none

module ser_par2ser (
   input  logic           clk,
   input  logic           tx_capture,
   input  logic           tx_shift,
   input  logic           lsbfirst,
   input  ser_pkg::word_t tx_data,
   output ser_pkg::lane_t ser_data_out
);
   import ser_pkg::*;

   // Holds the word being sent
   word_t sreg;

   // ##########################################################
   // Shift register
   // ##########################################################

   // Capture has priority, the controller never asks for both
   // LSB first moves the word down, the bottom lane leaves first
   // MSB first moves the word up, the top lane leaves first
   always_ff @(posedge clk) begin
      if (tx_capture) begin
         sreg <= tx_data;
      end else if (tx_shift) begin
         if (lsbfirst) begin
            sreg <= {{SW{1'b0}}, sreg[PW-1:SW]};
         end else begin
            sreg <= {sreg[PW-SW-1:0], {SW{1'b0}}};
         end
      end
   end

   // ##########################################################
   // Output lane
   // ##########################################################

   // Current beat sits at the end the word moves toward
   always_comb begin
      if (lsbfirst) begin
         ser_data_out = sreg[SW-1:0];
      end else begin
         ser_data_out = sreg[PW-1:PW-SW];
      end
   end

   // Vacated lanes fill with zero
   // Only the first BEATS lanes after a capture carry data

endmodule

`default_nettype wire

/* logic/ser_ser2par.sv */
`default_nettype none

module ser_ser2par (
   input  logic           clk,
   input  logic           shift,
   input  logic           lsbfirst,
   input  ser_pkg::lane_t ser_data_in,
   output ser_pkg::word_t rx_data
);
   import ser_pkg::*;

   // ##########################################################
   // Collecting shift register
   // ##########################################################

   // LSB first
   // new lane enters at the top, the word moves down
   // first beat ends in the bottom lane after BEATS shifts

   // MSB first
   // new lane enters at the bottom, the word moves up
   // first beat ends in the top lane after BEATS shifts

   always_ff @(posedge clk) begin
      if (shift) begin
         if (lsbfirst) begin
            rx_data <= {ser_data_in, rx_data[PW-1:SW]};
         end else begin
            rx_data <= {rx_data[PW-SW-1:0], ser_data_in};
         end
      end
   end

   // Word holds while shift is low
   // So it stays stable during the valid cycle

endmodule

`default_nettype wire

/* logic/ser_tx_ctrl.sv */
`default_nettype none

module ser_tx_ctrl (
   input  logic clk,
   input  logic rst,
   input  logic tx_load,
   output logic tx_capture,
   output logic tx_shift,
   output logic ser_frame_out,
   output logic tx_busy
);
   import ser_pkg::*;

   tx_state_t state;
   cnt_t      beat_cnt;

   // Final beat of the current word on the wire
   logic      last_beat;

   // Load taken this cycle
   logic      accept;

   // ##########################################################
   // Decode
   // ##########################################################

   always_comb begin
      last_beat = (state == TX_SEND) && (beat_cnt == cnt_t'(BEATS - 1));

      // Busy drops in the last beat so a new word can chain on
      tx_busy = (state == TX_SEND) && !last_beat;

      // Loads while busy are dropped
      accept = tx_load && !tx_busy;
   end

   // Word register loads on the accepting edge
   assign tx_capture = accept;

   // Advance every beat except the last
   // After the last beat the register is either reloaded or idle
   assign tx_shift = (state == TX_SEND) && !last_beat;

   // Frame covers all BEATS cycles of a word
   assign ser_frame_out = (state == TX_SEND);

   // ##########################################################
   // Sequencer
   // ##########################################################

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= TX_IDLE;
         beat_cnt <= '0;
      end else begin
         unique case (state)
            TX_IDLE: begin
               beat_cnt <= '0;
               if (accept) begin
                  state <= TX_SEND;
               end
            end
            TX_SEND: begin
               if (last_beat) begin
                  // Counter restarts for a chained word
                  beat_cnt <= '0;
                  if (!accept) begin
                     state <= TX_IDLE;
                  end
               end else begin
                  beat_cnt <= beat_cnt + cnt_t'(1);
               end
            end
            default: begin
               state    <= TX_IDLE;
               beat_cnt <= '0;
            end
         endcase
      end
   end

   // A chained load keeps TX_SEND, so the frame has no gap

endmodule

`default_nettype wire

/* logic/ser_rx_ctrl.sv */
`default_nettype none

module ser_rx_ctrl (
   input  logic clk,
   input  logic rst,
   input  logic ser_frame_in,
   output logic rx_valid,
   output logic rx_error
);
   import ser_pkg::*;

   rx_state_t state;

   // Beats taken so far in this word
   cnt_t      beat_cnt;

   // Frame sample completes a word
   logic      word_done;

   // ##########################################################
   // Decode
   // ##########################################################

   // Sixteenth beat seen with the frame still high
   assign word_done = (state == RX_COLLECT) && ser_frame_in &&
                      (beat_cnt == cnt_t'(BEATS - 1));

   // ##########################################################
   // Framer
   // ##########################################################

   // Every edge with frame high is one beat
   // The data shifter uses the same level as its shift
   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= RX_IDLE;
         beat_cnt <= '0;
         rx_valid <= 1'b0;
         rx_error <= 1'b0;
      end else begin
         // Both flags are single cycle pulses
         rx_valid <= 1'b0;
         rx_error <= 1'b0;
         unique case (state)
            RX_IDLE: begin
               if (ser_frame_in) begin
                  // First beat of a new word
                  state    <= RX_COLLECT;
                  beat_cnt <= cnt_t'(1);
               end
            end
            RX_COLLECT: begin
               if (word_done) begin
                  // Wrap so the next frame can follow directly
                  rx_valid <= 1'b1;
                  beat_cnt <= '0;
                  state    <= RX_IDLE;
               end else if (ser_frame_in) begin
                  beat_cnt <= beat_cnt + cnt_t'(1);
               end else begin
                  // Frame fell mid word
                  // Partial data is dropped, never flagged valid
                  rx_error <= 1'b1;
                  beat_cnt <= '0;
                  state    <= RX_IDLE;
               end
            end
            default: begin
               state    <= RX_IDLE;
               beat_cnt <= '0;
            end
         endcase
      end
   end

   // Idle with frame low is normal line rest
   // Count is always zero in RX_IDLE

endmodule

`default_nettype wire

/* logic/ser_link_top.sv */
`default_nettype none

module ser_link_top (
   input  logic           clk,
   input  logic           rst,

   // Parallel transmit side
   input  ser_pkg::word_t tx_data,
   input  logic           tx_load,
   input  logic           lsbfirst,
   output logic           tx_busy,

   // Serial transmit lines
   output ser_pkg::lane_t ser_data_out,
   output logic           ser_frame_out,

   // Serial receive lines
   input  ser_pkg::lane_t ser_data_in,
   input  logic           ser_frame_in,

   // Parallel receive side
   output ser_pkg::word_t rx_data,
   output logic           rx_valid,
   output logic           rx_error
);

   // ##########################################################
   // Transmit path
   // ##########################################################

   // Sequencer to shifter strobes
   logic tx_capture;
   logic tx_shift;

   // Load handshake, beat count and frame level
   ser_tx_ctrl u_tx_ctrl (
      .clk           (clk),
      .rst           (rst),
      .tx_load       (tx_load),
      .tx_capture    (tx_capture),
      .tx_shift      (tx_shift),
      .ser_frame_out (ser_frame_out),
      .tx_busy       (tx_busy)
   );

   // Word register shifting one lane out per beat
   ser_par2ser u_par2ser (
      .clk          (clk),
      .tx_capture   (tx_capture),
      .tx_shift     (tx_shift),
      .lsbfirst     (lsbfirst),
      .tx_data      (tx_data),
      .ser_data_out (ser_data_out)
   );

   // ##########################################################
   // Receive path
   // ##########################################################

   // Beat counting, valid and short frame detection
   ser_rx_ctrl u_rx_ctrl (
      .clk          (clk),
      .rst          (rst),
      .ser_frame_in (ser_frame_in),
      .rx_valid     (rx_valid),
      .rx_error     (rx_error)
   );

   // Frame level doubles as the shift enable
   ser_ser2par u_ser2par (
      .clk         (clk),
      .shift       (ser_frame_in),
      .lsbfirst    (lsbfirst),
      .ser_data_in (ser_data_in),
      .rx_data     (rx_data)
   );

   // Bit order is one level for both directions
   // Hold it steady from load to the matching rx_valid

endmodule

`default_nettype wire

/* tb/ser_link_tb.sv */
`default_nettype none

module ser_link_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import ser_pkg::*;

   localparam int NROWS     = 11;
   // Run limit from the table length
   localparam int CYC_LIMIT = 40 * NROWS + 100;
   localparam int EXP_DEPTH = CYC_LIMIT + 64;

   logic  clk;
   logic  rst;
   word_t tx_data;
   logic  tx_load;
   logic  lsbfirst;
   logic  tx_busy;
   lane_t ser_data_out;
   logic  ser_frame_out;
   lane_t ser_data_in;
   logic  ser_frame_in;
   word_t rx_data;
   logic  rx_valid;
   logic  rx_error;

   // Stimulus table, one word per row
   // Truncation zero means a full frame
   word_t row_word  [NROWS];
   logic  row_lsb   [NROWS];
   int    row_trunc [NROWS];
   logic  row_b2b   [NROWS];

   // Expected outputs indexed by cycle
   bit    exp_busy  [EXP_DEPTH];
   bit    exp_frame [EXP_DEPTH];
   bit    exp_valid [EXP_DEPTH];
   bit    exp_error [EXP_DEPTH];
   lane_t exp_lane  [EXP_DEPTH];
   word_t exp_data  [EXP_DEPTH];

   int     cyc;
   int     last_event;
   int     trunc_beats;
   int     wire_beat;
   bit     checking;
   int     mismatches;
   int     other_errors;
   int     valid_seen;
   int     valid_expected;
   integer seed;

   ser_link_top dut0 (
      .clk           (clk),
      .rst           (rst),
      .tx_data       (tx_data),
      .tx_load       (tx_load),
      .lsbfirst      (lsbfirst),
      .tx_busy       (tx_busy),
      .ser_data_out  (ser_data_out),
      .ser_frame_out (ser_frame_out),
      .ser_data_in   (ser_data_in),
      .ser_frame_in  (ser_frame_in),
      .rx_data       (rx_data),
      .rx_valid      (rx_valid),
      .rx_error      (rx_error)
   );

   // ##########################################################
   // Clock, cycle count, timeout
   // ##########################################################

   always #4 clk = ~clk;

   // After edge n the count reads n
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= CYC_LIMIT) begin
         other_errors = other_errors + 1;
         $display("timeout: run did not finish within %0d cycles", CYC_LIMIT);
         $display("summary: %0d mismatches, %0d other errors", mismatches, other_errors);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // ##########################################################
   // Loopback with optional truncation
   // ##########################################################

   // One register stage, so receive lags transmit by a cycle
   // wire_beat tracks the beat on the wire, frames are always 16 long
   always @(posedge clk) begin
      if (rst) begin
         ser_data_in  <= '0;
         ser_frame_in <= 1'b0;
         wire_beat    <= 0;
      end else begin
         ser_data_in  <= ser_data_out;
         ser_frame_in <= ser_frame_out && (trunc_beats == 0 || wire_beat < trunc_beats);
         if (ser_frame_out) begin
            wire_beat <= (wire_beat == BEATS - 1) ? 0 : wire_beat + 1;
         end
      end
   end

   // ##########################################################
   // Compare tasks and monitor
   // ##########################################################

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_lane(input string what, input lane_t got, input lane_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_word(input string what, input word_t got, input word_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Outputs settle well before the falling edge
   always @(negedge clk) begin
      if (checking) begin
         check_flag("tx_busy", tx_busy, exp_busy[cyc]);
         check_flag("ser_frame_out", ser_frame_out, exp_frame[cyc]);
         check_flag("rx_valid", rx_valid, exp_valid[cyc]);
         check_flag("rx_error", rx_error, exp_error[cyc]);
         if (exp_frame[cyc]) begin
            check_lane("ser_data_out", ser_data_out, exp_lane[cyc]);
         end
         if (exp_valid[cyc]) begin
            check_word("rx_data", rx_data, exp_data[cyc]);
         end
         if (rx_valid === 1'b1) begin
            valid_seen++;
         end
      end
   end

   // ##########################################################
   // Stimulus helpers
   // ##########################################################

   function automatic word_t rand_word();
      word_t w;
      w[63:32] = $random(seed);
      w[31:0]  = $random(seed);
      return w;
   endfunction

   task automatic set_row(input int r, input word_t w, input logic lsb, input int tr,
                          input logic b2b);
      row_word[r]  = w;
      row_lsb[r]   = lsb;
      row_trunc[r] = tr;
      row_b2b[r]   = b2b;
   endtask

   // Chained rows follow a full row with the same bit order
   task automatic fill_table();
      set_row(0, 64'h0123_4567_89ab_cdef, 1'b0, 0, 1'b0);
      set_row(1, 64'h0123_4567_89ab_cdef, 1'b1, 0, 1'b0);
      set_row(2, rand_word(), 1'b0, 0, 1'b0);
      set_row(3, rand_word(), 1'b0, 0, 1'b1);
      set_row(4, rand_word(), 1'b1, 0, 1'b0);
      set_row(5, rand_word(), 1'b1, 0, 1'b1);
      set_row(6, 64'h5a5a_c3c3_0ff0_9669, 1'b0, 5, 1'b0);
      set_row(7, rand_word(), 1'b0, 0, 1'b0);
      set_row(8, rand_word(), 1'b1, 1, 1'b0);
      set_row(9, rand_word(), 1'b1, 15, 1'b0);
      set_row(10, 64'h8000_0000_0000_0001, 1'b1, 0, 1'b0);
   endtask

   // Word accepted at edge k
   // Frame in cycles k to k+15, busy in all but the last
   // Loopback stage plus 16 beats puts rx_valid at k+17
   // A cut after n beats shows rx_error at k+n+2
   task automatic predict_word(input int k, input word_t w, input logic lsb, input int tr);
      int i;
      for (i = 0; i < BEATS; i++) begin
         exp_frame[k+i] = 1'b1;
         if (i < BEATS - 1) begin
            exp_busy[k+i] = 1'b1;
         end
         if (lsb) begin
            exp_lane[k+i] = w[i*SW +: SW];
         end else begin
            exp_lane[k+i] = w[PW-SW-i*SW +: SW];
         end
      end
      if (tr == 0) begin
         exp_valid[k+BEATS+1] = 1'b1;
         exp_data[k+BEATS+1]  = w;
         valid_expected++;
      end else begin
         exp_error[k+tr+2] = 1'b1;
      end
      last_event = k + BEATS + 1;
   endtask

   // Returns on the accepting edge
   // cyc still holds the count from before that edge
   task automatic load_word(input word_t w, input logic lsb, output int k);
      @(posedge clk);
      tx_data  <= w;
      lsbfirst <= lsb;
      tx_load  <= 1'b1;
      @(posedge clk);
      tx_load  <= 1'b0;
      k = cyc + 1;
   endtask

   // Both directions quiet, bit order may change
   task automatic wait_idle();
      @(negedge clk);
      while (cyc <= last_event) begin
         @(negedge clk);
      end
   endtask

   // ##########################################################
   // Main sequence
   // ##########################################################

   initial begin : main_seq
      int r;
      int k;
      clk            = 1'b0;
      rst            = 1'b1;
      tx_data        = '0;
      tx_load        = 1'b0;
      lsbfirst       = 1'b0;
      ser_data_in    = '0;
      ser_frame_in   = 1'b0;
      cyc            = 0;
      last_event     = 0;
      trunc_beats    = 0;
      wire_beat      = 0;
      checking       = 1'b0;
      mismatches     = 0;
      other_errors   = 0;
      valid_seen     = 0;
      valid_expected = 0;
      seed           = 32'h0579fc22;
      fill_table();

      repeat (16) @(posedge clk);
      rst <= 1'b0;
      // First check sees the reset values
      checking = 1'b1;

      for (r = 0; r < NROWS; r++) begin
         if (row_b2b[r]) begin
            // Load lands in the last beat of the previous word
            repeat (BEATS - 2) @(posedge clk);
         end else begin
            wait_idle();
            trunc_beats = row_trunc[r];
         end
         load_word(row_word[r], row_lsb[r], k);
         predict_word(k, row_word[r], row_lsb[r], row_trunc[r]);
      end

      // Second load sampled two beats into the frame
      wait_idle();
      trunc_beats = 0;
      load_word(64'h0f1e_2d3c_4b5a_6978, 1'b0, k);
      predict_word(k, 64'h0f1e_2d3c_4b5a_6978, 1'b0, 0);
      repeat (2) @(posedge clk);
      tx_data <= 64'h7766_5544_3322_1100;
      tx_load <= 1'b1;
      @(posedge clk);
      tx_load <= 1'b0;

      wait_idle();
      repeat (4) @(negedge clk);

      if (valid_seen != valid_expected) begin
         other_errors++;
         $display("rx_valid pulsed %0d times but %0d full words were sent",
                  valid_seen, valid_expected);
      end
      $display("summary: %0d mismatches, %0d other errors", mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
logic/ser_pkg.sv
logic/ser_par2ser.sv
logic/ser_ser2par.sv
logic/ser_tx_ctrl.sv
logic/ser_rx_ctrl.sv
logic/ser_link_top.sv
tb/ser_link_tb.sv
